/* files.f */
src/bt_pkt_pkg.sv
src/bt_code_pkg.sv
src/header_bitp.sv
src/payload_bitp.sv
src/tx_whiten_sel.sv
src/bitp_top.sv
bench/bitp_properties.sv
bench/bitp_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= bitp_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Test failed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

# a run counts as failed on the fail message or a nonzero exit
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation run failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/bitp_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module bitp_tb;

  import bt_pkt_pkg::*;

  logic        clk_6M;
  logic        arst_n;
  logic        p_1us;
  logic        tx_packet_st_p;
  hdr_fields_t hdr;
  logic [7:0]  uap;
  logic [5:0]  clk_bt;
  logic        txwhitening;
  logic [9:0]  payloadlen;
  logic [7:0]  py_byte;
  wire         txbit;
  wire         txbit_period;
  wire         py_byte_req;
  wire         tx_done_p;

  logic [31:0] rng_state = 32'h5a53_35e6;
  logic        exp_q[$];  // expected air bits over all packets
  logic [7:0]  pay_q[$];  // payload bytes in request order
  int          pkt_len[7];
  int          bit_idx = 0;
  int          req_cnt = 0;
  int          done_cnt = 0;
  int          bytes_sent = 0;
  int          bit_errors = 0;
  int          cnt_errors = 0;
  int          err_mark = 0;
  int          tests_failed = 0;
  int          budget_cycles = 0;

  bitp_top #(.PY_LEN_W(10)) UUT (.*);

  initial begin
    clk_6M = 1'b0;
    forever #10 clk_6M = ~clk_6M;
  end

  // 1 us strobe, one cycle in six
  initial begin
    p_1us = 1'b0;
    forever begin
      repeat (5) @(negedge clk_6M);
      p_1us = 1'b1;
      @(negedge clk_6M);
      p_1us = 1'b0;
    end
  end

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic int total_errors();
    return bit_errors + cnt_errors;
  endfunction

  // expected air bits: header lsb first, hec msb first, bytes lsb first, crc msb first
  task automatic build_packet(input logic [9:0] hbits, input logic [7:0] seed,
                              input logic [5:0] wseed, input logic white, input int len);
    logic [7:0]  hec;
    logic [15:0] crc;
    logic [6:0]  wreg;
    logic [31:0] r;
    logic        fb;
    logic        wout;
    logic        raw[$];
    hec = seed;
    for (int i = 0; i < 10; i++) begin
      raw.push_back(hbits[i]);
      fb  = hec[7] ^ hbits[i];
      hec = {hec[6:0], 1'b0} ^ (fb ? 8'ha7 : 8'h00);
    end
    for (int i = 7; i >= 0; i--) raw.push_back(hec[i]);
    crc = {8'h00, seed};
    for (int n = 0; n < len; n++) begin
      r = next_rand();
      pay_q.push_back(r[7:0]);
      for (int j = 0; j < 8; j++) begin
        raw.push_back(r[j]);
        fb  = crc[15] ^ r[j];
        crc = {crc[14:0], 1'b0} ^ (fb ? 16'h1021 : 16'h0000);
      end
    end
    for (int i = 15; i >= 0; i--) raw.push_back(crc[i]);
    wreg = {1'b1, wseed};
    foreach (raw[k]) begin
      wout = wreg[6];
      exp_q.push_back(raw[k] ^ (white & wout));
      wreg = {wreg[5:0], wout} ^ (wout ? 7'h10 : 7'h00);  // x^7+x^4+1
    end
  endtask

  // bit checks at each strobe, counted pulses
  initial begin
    forever begin
      @(posedge clk_6M);
      if (arst_n) begin
        if (py_byte_req) req_cnt++;
        if (tx_done_p) done_cnt++;
        if (p_1us && txbit_period) begin
          if (bit_idx < exp_q.size()) begin
            assert (txbit === exp_q[bit_idx]) else begin
              $display("[FAIL] %0t txbit (bit %0d) expected %b got %b",
                       $time, bit_idx, exp_q[bit_idx], txbit);
              bit_errors++;
            end
          end else begin
            $display("txbit_period still high at %0t after the packet should have ended",
                     $time);
            bit_errors++;
          end
          bit_idx++;
        end
      end
    end
  end

  // answers each request before the next strobe
  initial begin
    py_byte = 8'h00;
    forever begin
      @(negedge clk_6M);
      if (bytes_sent < req_cnt) begin
        py_byte = (bytes_sent < pay_q.size()) ? pay_q[bytes_sent] : 8'h00;
        bytes_sent++;
      end
    end
  end

  task automatic check_count(input string name, input int exp_val, input int got);
    assert (got == exp_val) else begin
      $display("[FAIL] %0t %s count expected %0d got %0d", $time, name, exp_val, got);
      cnt_errors++;
    end
  endtask

  task automatic run_packet(input int len, input logic white, input logic restart);
    logic [31:0] r;
    int          req_before;
    int          done_before;
    r = next_rand();
    @(negedge clk_6M);
    hdr         = hdr_fields_t'(r[9:0]);
    uap         = r[17:10];
    clk_bt      = r[23:18];
    txwhitening = white;
    payloadlen  = 10'(len);
    build_packet(r[9:0], r[17:10], r[23:18], white, len);
    req_before  = req_cnt;
    done_before = done_cnt;
    tx_packet_st_p = 1'b1;
    @(negedge clk_6M);
    tx_packet_st_p = 1'b0;
    if (restart) begin
      repeat (150) @(negedge clk_6M);  // lands in the payload
      tx_packet_st_p = 1'b1;
      @(negedge clk_6M);
      tx_packet_st_p = 1'b0;
    end
    while (done_cnt == done_before) @(negedge clk_6M);
    repeat (12) @(negedge clk_6M);  // no bits may follow
    check_count("txbit_period bit", exp_q.size(), bit_idx);
    check_count("py_byte_req", len, req_cnt - req_before);
    check_count("tx_done_p", 1, done_cnt - done_before);
  endtask

  task automatic end_test(input int num, input string name);
    if (total_errors() == err_mark) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: %0d errors", num, name, total_errors() - err_mark);
      tests_failed++;
    end
    err_mark = total_errors();
  endtask

  initial begin
    logic [31:0] r;
    tx_packet_st_p = 1'b0;
    hdr            = '0;
    uap            = 8'h00;
    clk_bt         = 6'h00;
    txwhitening    = 1'b0;
    payloadlen     = '0;
    arst_n         = 1'b0;
    pkt_len[0] = 2;
    for (int i = 1; i < 7; i++) begin
      r = next_rand();
      pkt_len[i] = int'(r[2:0]) + 1;
    end
    pkt_len[5] = 0;
    for (int i = 0; i < 7; i++) begin
      budget_cycles = budget_cycles + (18 + 8 * pkt_len[i] + 16) * 6 + 100;
    end
    budget_cycles = budget_cycles + 200;  // reset and idle
    repeat (10) @(negedge clk_6M);
    arst_n = 1'b1;
    repeat (30) begin
      @(posedge clk_6M);
      assert (!txbit_period && !txbit && !py_byte_req && !tx_done_p) else begin
        $display("[FAIL] %0t idle outputs expected 0 got period %b txbit %b req %b done %b",
                 $time, txbit_period, txbit, py_byte_req, tx_done_p);
        cnt_errors++;
      end
    end
    end_test(1, "reset and idle");
    run_packet(pkt_len[0], 1'b0, 1'b0);
    end_test(2, "header and HEC");
    for (int i = 1; i < 4; i++) run_packet(pkt_len[i], 1'b0, 1'b0);
    end_test(3, "payload and CRC");
    run_packet(pkt_len[4], 1'b1, 1'b0);
    end_test(4, "whitening");
    run_packet(pkt_len[5], 1'b0, 1'b0);
    end_test(5, "zero-length payload");
    run_packet(pkt_len[6], 1'b1, 1'b1);
    end_test(6, "start pulse during a packet");
    $display("tests 6, failed %0d, bits checked %0d, errors %0d",
             tests_failed, bit_idx, total_errors());
    if (total_errors() == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    wait (budget_cycles > 0);
    repeat (budget_cycles) @(posedge clk_6M);
    $display("watchdog expired after %0d cycles, a packet never finished", budget_cycles);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* bench/bitp_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module bitp_properties (
  input logic                  clk_6M,
  input logic                  arst_n,
  input logic                  p_1us,
  input bt_pkt_pkg::hdr_ctrl_t hdr_tx,
  input bt_pkt_pkg::hdr_ctrl_t py_tx,
  input logic                  txbit,
  input logic                  txbit_period,
  input logic                  py_byte_req,
  input logic                  tx_done_p
);

  logic       hdr_period;
  logic       py_period;
  logic [4:0] hdr_strobes; // strobes inside the current header

  assign hdr_period = hdr_tx.period;
  assign py_period  = py_tx.period;

  always_ff @(posedge clk_6M or negedge arst_n) begin
    if (!arst_n) begin
      hdr_strobes <= '0;
    end else if (hdr_period && p_1us) begin
      hdr_strobes <= hdr_strobes + 5'd1;
    end else if (!hdr_period) begin
      hdr_strobes <= '0;
    end
  end

  txbit_low_idle: assert property (@(posedge clk_6M) disable iff (!arst_n)
    !txbit_period |-> !txbit)
    else $error("txbit high outside txbit_period");

  outputs_low_reset: assert property (@(posedge clk_6M)
    (!arst_n || $rose(arst_n)) |-> !(txbit_period || txbit || py_byte_req || tx_done_p))
    else $error("outputs not low during or right after reset");

  hdr_len_18: assert property (@(posedge clk_6M) disable iff (!arst_n)
    $fell(hdr_period) |-> hdr_strobes == 5'd18)
    else $error("header period did not cover 18 strobes");

  req_in_span: assert property (@(posedge clk_6M) disable iff (!arst_n)
    py_byte_req |-> (hdr_period || py_period))
    else $error("py_byte_req outside the header to payload span");

  done_at_end: assert property (@(posedge clk_6M) disable iff (!arst_n)
    $fell(py_period) |-> tx_done_p)
    else $error("no tx_done_p after the payload period");

  done_only_end: assert property (@(posedge clk_6M) disable iff (!arst_n)
    tx_done_p |-> ($past(py_period) && !py_period))
    else $error("tx_done_p without the end of a payload period");

endmodule

bind bitp_top bitp_properties bitp_properties_u (
  .clk_6M       (clk_6M      ),
  .arst_n       (arst_n      ),
  .p_1us        (p_1us       ),
  .hdr_tx       (hdr_tx      ),
  .py_tx        (py_tx       ),
  .txbit        (txbit       ),
  .txbit_period (txbit_period),
  .py_byte_req  (py_byte_req ),
  .tx_done_p    (tx_done_p   )
);

`default_nettype wire

/* src/bitp_top.sv */
`timescale 1ns/1ps
`default_nettype none

module bitp_top #(
  parameter int PY_LEN_W = 10
) (
  input  logic                    clk_6M,
  input  logic                    arst_n,
  input  logic                    p_1us,
  input  logic                    tx_packet_st_p,
  input  bt_pkt_pkg::hdr_fields_t hdr,
  input  logic [7:0]              uap,
  input  logic [5:0]              clk_bt,
  input  logic                    txwhitening,
  input  logic [PY_LEN_W-1:0]     payloadlen,
  input  logic [7:0]              py_byte,
  output logic                    txbit,
  output logic                    txbit_period,
  output logic                    py_byte_req,
  output logic                    tx_done_p
);

  import bt_pkt_pkg::*;

  hdr_ctrl_t hdr_tx;
  hdr_ctrl_t py_tx;
  wire       py_st_p;
  wire       py_endp;

  // restart is dropped anywhere inside a packet
  wire       pkt_st_p = tx_packet_st_p & ~txbit_period;

  header_bitp header_bitp_u (
    .clk_6M         (clk_6M      ),
    .arst_n         (arst_n      ),
    .p_1us          (p_1us       ),
    .tx_packet_st_p (pkt_st_p    ),
    .hdr            (hdr         ),
    .uap            (uap         ),
    .hdr_tx         (hdr_tx      ),
    .py_st_p        (py_st_p     )
  );

  payload_bitp #(
    .PY_LEN_W (PY_LEN_W)
  ) payload_bitp_u (
    .clk_6M      (clk_6M     ),
    .arst_n      (arst_n     ),
    .p_1us       (p_1us      ),
    .py_st_p     (py_st_p    ),
    .payloadlen  (payloadlen ),
    .uap         (uap        ),
    .py_byte     (py_byte    ),
    .py_byte_req (py_byte_req),
    .py_tx       (py_tx      ),
    .py_endp     (py_endp    )
  );

  tx_whiten_sel tx_whiten_sel_u (
    .clk_6M         (clk_6M      ),
    .arst_n         (arst_n      ),
    .p_1us          (p_1us       ),
    .tx_packet_st_p (pkt_st_p    ),
    .clk_bt         (clk_bt      ),
    .txwhitening    (txwhitening ),
    .hdr_tx         (hdr_tx      ),
    .py_tx          (py_tx       ),
    .py_endp        (py_endp     ),
    .txbit          (txbit       ),
    .txbit_period   (txbit_period),
    .tx_done_p      (tx_done_p   )
  );

endmodule

`default_nettype wire

/* src/tx_whiten_sel.sv */
`timescale 1ns/1ps
`default_nettype none

module tx_whiten_sel (
  input  logic                  clk_6M,
  input  logic                  arst_n,
  input  logic                  p_1us,
  input  logic                  tx_packet_st_p,
  input  logic [5:0]            clk_bt,
  input  logic                  txwhitening,
  input  bt_pkt_pkg::hdr_ctrl_t hdr_tx,
  input  bt_pkt_pkg::hdr_ctrl_t py_tx,
  input  logic                  py_endp,
  output logic                  txbit,
  output logic                  txbit_period,
  output logic                  tx_done_p
);

  import bt_code_pkg::*;

  localparam logic [WHITE_BITS-1:0] WHITE_MASK = WHITE_BITS'(1) << WHITE_TAP;

  logic [WHITE_BITS-1:0] white_q;
  logic [WHITE_BITS-1:0] white_nxt;
  logic                  white_out;
  logic                  sel_bit;

  assign white_out = white_q[WHITE_BITS-1];
  assign white_nxt = {white_q[WHITE_BITS-2:0], white_out} ^
                     (WHITE_MASK & {WHITE_BITS{white_out}});

  // one sequence runs through header and payload
  always_ff @(posedge clk_6M or negedge arst_n) begin
    if (!arst_n) begin
      white_q <= '0;
    end else if (tx_packet_st_p) begin
      white_q <= {1'b1, clk_bt};
    end else if (p_1us && txbit_period) begin
      white_q <= white_nxt;
    end
  end

  always_ff @(posedge clk_6M or negedge arst_n) begin
    if (!arst_n) begin
      tx_done_p <= 1'b0;
    end else begin
      tx_done_p <= py_endp;
    end
  end

  assign txbit_period = hdr_tx.period | py_tx.period;
  assign sel_bit      = hdr_tx.period ? hdr_tx.bit_val : py_tx.bit_val;
  assign txbit        = txbit_period & (sel_bit ^ (txwhitening & white_out)); // 0 when idle

endmodule

`default_nettype wire

/* src/payload_bitp.sv */
`timescale 1ns/1ps
`default_nettype none

module payload_bitp #(
  parameter int PY_LEN_W = 10
) (
  input  logic                  clk_6M,
  input  logic                  arst_n,
  input  logic                  p_1us,
  input  logic                  py_st_p,
  input  logic [PY_LEN_W-1:0]   payloadlen,
  input  logic [7:0]            uap,
  input  logic [7:0]            py_byte,
  output logic                  py_byte_req,
  output bt_pkt_pkg::hdr_ctrl_t py_tx,
  output logic                  py_endp
);

  import bt_code_pkg::*;

  logic                period_q;
  logic                crc_phase;   // sending the 16 check bits
  logic [2:0]          bit_cnt;     // bit within current byte
  logic [3:0]          crc_cnt;
  logic [PY_LEN_W-1:0] bytes_left;
  logic [6:0]          sh_q;        // rest of the byte on air
  logic [CRC_BITS-1:0] crc_q;
  logic                step;
  logic                data_step;
  logic                last_byte;
  logic                empty;
  logic                cur_bit;
  logic                crc_fb;

  assign step      = period_q & p_1us;
  assign data_step = step & ~crc_phase;
  assign last_byte = (bytes_left == PY_LEN_W'(1));
  assign empty     = (payloadlen == '0);

  // bit 0 of a byte is taken straight off py_byte, sampled at the strobe ending it
  assign cur_bit = crc_phase         ? crc_q[CRC_BITS-1] :
                   (bit_cnt == 3'd0) ? py_byte[0]        : sh_q[0];

  assign crc_fb = crc_q[CRC_BITS-1] ^ cur_bit;

  always_ff @(posedge clk_6M or negedge arst_n) begin
    if (!arst_n) begin
      period_q   <= 1'b0;
      crc_phase  <= 1'b0;
      bit_cnt    <= '0;
      crc_cnt    <= '0;
      bytes_left <= '0;
    end else if (py_st_p) begin
      period_q   <= 1'b1;
      crc_phase  <= empty; // no data, straight to crc
      bit_cnt    <= '0;
      crc_cnt    <= '0;
      bytes_left <= payloadlen;
    end else if (data_step) begin
      bit_cnt <= bit_cnt + 3'd1;
      if (bit_cnt == 3'd7) begin
        bytes_left <= bytes_left - PY_LEN_W'(1);
        if (last_byte) begin
          crc_phase <= 1'b1;
        end
      end
    end else if (step) begin
      crc_cnt <= crc_cnt + 4'd1;
      if (crc_cnt == 4'(CRC_BITS-1)) begin
        period_q  <= 1'b0;
        crc_phase <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_6M) begin
    if (py_st_p) begin
      crc_q <= {{(CRC_BITS-8){1'b0}}, uap};
    end else if (data_step) begin
      if (bit_cnt == 3'd0) begin
        sh_q <= py_byte[7:1];
      end else begin
        sh_q <= sh_q >> 1;
      end
      crc_q <= {crc_q[CRC_BITS-2:0], 1'b0} ^ (CRC_POLY & {CRC_BITS{crc_fb}});
    end else if (step) begin
      crc_q <= crc_q << 1;
    end
  end

  // first byte asked for with py_st_p, the others at the strobe ending bit 7
  assign py_byte_req = (py_st_p & ~empty) |
                       (data_step & (bit_cnt == 3'd7) & ~last_byte);

  assign py_endp = step & crc_phase & (crc_cnt == 4'(CRC_BITS-1));

  assign py_tx = '{period: period_q, bit_val: cur_bit};

endmodule

`default_nettype wire

/* src/header_bitp.sv */
`timescale 1ns/1ps
`default_nettype none

module header_bitp (
  input  logic                    clk_6M,
  input  logic                    arst_n,
  input  logic                    p_1us,
  input  logic                    tx_packet_st_p,
  input  bt_pkt_pkg::hdr_fields_t hdr,
  input  logic [7:0]              uap,
  output bt_pkt_pkg::hdr_ctrl_t   hdr_tx,
  output logic                    py_st_p
);

  import bt_pkt_pkg::*;
  import bt_code_pkg::*;

  localparam int LAST_BIT = HDR_BITS + HEC_BITS - 1;

  logic                period_q;
  logic [4:0]          bit_cnt;
  logic [HDR_BITS-1:0] hdr_q;
  logic [HEC_BITS-1:0] hec_q;
  logic                start;
  logic                step;
  logic                in_hec;
  logic                hec_fb;
  logic                cur_bit;

  assign start  = tx_packet_st_p & ~period_q; // busy header ignores a restart
  assign step   = period_q & p_1us;
  assign in_hec = (bit_cnt >= 5'(HDR_BITS));

  // lfsr feedback, header bit enters at the top
  assign hec_fb = hec_q[HEC_BITS-1] ^ hdr_q[0];

  // hec goes out msb first
  assign cur_bit = in_hec ? hec_q[HEC_BITS-1] : hdr_q[0];

  always_ff @(posedge clk_6M or negedge arst_n) begin
    if (!arst_n) begin
      period_q <= 1'b0;
      bit_cnt  <= '0;
    end else if (start) begin
      period_q <= 1'b1;
      bit_cnt  <= '0;
    end else if (step) begin
      bit_cnt <= bit_cnt + 5'd1;
      if (bit_cnt == 5'(LAST_BIT)) begin
        period_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_6M) begin
    if (start) begin
      hdr_q <= hdr;
      hec_q <= uap;
    end else if (step) begin
      if (!in_hec) begin
        hdr_q <= hdr_q >> 1;
        hec_q <= {hec_q[HEC_BITS-2:0], 1'b0} ^ (HEC_POLY & {HEC_BITS{hec_fb}});
      end else begin
        hec_q <= hec_q << 1;
      end
    end
  end

  // strobe closing the last hec bit hands over to the payload
  assign py_st_p = step & (bit_cnt == 5'(LAST_BIT));

  assign hdr_tx = '{period: period_q, bit_val: cur_bit};

endmodule

`default_nettype wire

/* src/bt_code_pkg.sv */
`default_nettype none

package bt_code_pkg;

  localparam int HEC_BITS   = 8;
  localparam int CRC_BITS   = 16;
  localparam int WHITE_BITS = 7;

  // D^8+D^7+D^5+D^2+D+1, top term implied
  localparam logic [HEC_BITS-1:0] HEC_POLY = 8'ha7;

  // CCITT x^16+x^12+x^5+1
  localparam logic [CRC_BITS-1:0] CRC_POLY = 16'h1021;

  // x^7+x^4+1
  // bit 6 is the output and wraps to bit 0, also xored in here
  localparam int WHITE_TAP = 4;

endpackage

`default_nettype wire

/* src/bt_pkt_pkg.sv */
`default_nettype none

package bt_pkt_pkg;

  localparam int LT_ADDR_BITS = 3;
  localparam int PK_TYPE_BITS = 4;

  // header bits ahead of the HEC
  localparam int HDR_BITS = LT_ADDR_BITS + PK_TYPE_BITS + 3;

  // packet header fields
  // lt_addr sits in the low bits so it leaves first when shifted out lsb first
  typedef struct packed {
    logic                    seqn;
    logic                    arqn;
    logic                    flow;
    logic [PK_TYPE_BITS-1:0] pk_type;
    logic [LT_ADDR_BITS-1:0] lt_addr;
  } hdr_fields_t;

  // per unit report to the bit combiner
  typedef struct packed {
    logic period;  // unit owns the air
    logic bit_val; // unwhitened bit
  } hdr_ctrl_t;

endpackage

`default_nettype wire
